/* rtl/act_buf.sv */
// Activation memory of the tile, distributed RAM with asynchronous read and one delay stage
`include "tile_cfg.svh"

module act_buf
   import tile_pkg::*;
(
   input  logic      clk_h,
   input  logic      rst_n,
   input  logic      act_we,
   input  act_addr_t act_wr_addr,   // From tile_ctrl, phase in the low bit
   input  act_t      act_wr_half,
   input  act_addr_t act_rd_addr,
   output act_t      act_rd_data_d  // Read data, one register after the array
);

   localparam int ActDepth = 1 << `TILE_ACT_ADDR_WIDTH;

   act_t mem [ActDepth];
   act_t act_rd_data;   // Combinational read

   initial begin
      for (int i = 0; i < ActDepth; i++) begin
         mem[i] = '0; // Starts cleared
      end
   end

   always_ff @(posedge clk_h) begin
      if (act_we) begin
         mem[act_wr_addr] <= act_wr_half;
      end
   end

   assign act_rd_data = mem[act_rd_addr]; // Async, sees pre-write contents at the edge

   // Delay register, lines the activation up with the weight output register
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         act_rd_data_d <= '0;
      end else begin
         act_rd_data_d <= act_rd_data;
      end
   end

   // Unknown read address would push X through the slice into the cascade chain
   a_rd_addr_known : assert property (
      @(posedge clk_h) disable iff (!rst_n)
      !$isunknown(act_rd_addr)
   ) else $error("Activation read address unknown");

endmodule

/* rtl/mac_slice.sv */
// Multiply-add slice of the tile, weight times activation plus the cascade input
`include "tile_cfg.svh"

module mac_slice
   import tile_pkg::*;
(
   input  logic    clk_h,
   input  logic    rst_n,
   input  weight_t w_rd_data,      // A operand
   input  act_t    act_rd_data_d,  // B operand
   input  acc_t    p_casin,        // Partial sum from the previous tile
   output acc_t    p_out           // Registered sum, also the cascade output
);

   localparam int ProdWidth = `TILE_W_WIDTH + `TILE_ACT_WIDTH;

   weight_t              a_q;   // A register
   act_t                 b_q;   // B register
   logic [ProdWidth-1:0] m_q;   // Product register
   acc_t                 p_q;   // Result register

   // Operand stage
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         a_q <= '0;
         b_q <= '0;
      end else begin
         a_q <= w_rd_data;
         b_q <= act_rd_data_d;
      end
   end

   // Multiplier stage, unsigned 16 x 16
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         m_q <= '0;
      end else begin
         m_q <= a_q * b_q;
      end
   end

   // Post-adder stage
   // Cascade input is taken unregistered, as PCIN on the DSP
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         p_q <= '0;
      end else begin
         p_q <= acc_t'(m_q) + p_casin; // Wraps at 48 bits
      end
   end

   assign p_out = p_q;

   // An X here would spread down the whole cascade chain
   a_p_out_known : assert property (
      @(posedge clk_h) disable iff (!rst_n)
      !$isunknown(p_out)
   ) else $error("Slice result unknown");

endmodule

/* rtl/super_tile.sv */
// Top level of one systolic MAC tile, chained through p_casin and p_out
module super_tile
   import tile_pkg::*;
(
   input  logic      clk_h,
   input  logic      rst_n,

   // Weight buffer ports
   input  logic      w_wr_en,
   input  w_addr_t   w_wr_addr,
   input  weight_t   w_wr_data,
   input  w_addr_t   w_rd_addr,

   // Activation buffer ports
   input  logic      act_wr_en,
   input  act_row_t  act_wr_row,
   input  act_pair_t act_wr_data,
   input  act_addr_t act_rd_addr,

   // Cascade
   input  acc_t      p_casin,
   output acc_t      p_out       // Feeds the next tile's p_casin
);

   logic      act_we;
   act_addr_t act_wr_addr;
   act_t      act_wr_half;
   weight_t   w_rd_data;
   act_t      act_rd_data_d;

   // Phase and pair split for activation writes
   tile_ctrl u_tile_ctrl (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .act_wr_en   (act_wr_en),
      .act_wr_row  (act_wr_row),
      .act_wr_data (act_wr_data),
      .act_we      (act_we),
      .act_wr_addr (act_wr_addr),
      .act_wr_half (act_wr_half)
   );

   weight_buf u_weight_buf (
      .clk_h     (clk_h),
      .rst_n     (rst_n),
      .w_wr_en   (w_wr_en),
      .w_wr_addr (w_wr_addr),
      .w_wr_data (w_wr_data),
      .w_rd_addr (w_rd_addr),
      .w_rd_data (w_rd_data)
   );

   act_buf u_act_buf (
      .clk_h         (clk_h),
      .rst_n         (rst_n),
      .act_we        (act_we),
      .act_wr_addr   (act_wr_addr),
      .act_wr_half   (act_wr_half),
      .act_rd_addr   (act_rd_addr),
      .act_rd_data_d (act_rd_data_d)
   );

   // Weight path is one stage longer, so its address leads by a cycle
   mac_slice u_mac_slice (
      .clk_h         (clk_h),
      .rst_n         (rst_n),
      .w_rd_data     (w_rd_data),
      .act_rd_data_d (act_rd_data_d),
      .p_casin       (p_casin),
      .p_out         (p_out)
   );

endmodule

/* rtl/tile_cfg.svh */
// Memory and accumulator shapes of one MAC tile, included by the package and the RTL
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Weight buffer, one 18K block RAM shaped 16 x 1024
`define TILE_W_WIDTH 16
`define TILE_W_DEPTH 1024
`define TILE_W_ADDR_WIDTH 10

// Power-up content of every weight word
`define TILE_W_INIT 16'h0001

// Activation buffer, 64 words of distributed RAM
`define TILE_ACT_WIDTH 16
`define TILE_ACT_ADDR_WIDTH 6   // 64 words, low bit comes from the write phase

// Cascade and result width of the multiply-add slice
`define TILE_ACC_WIDTH 48

`endif

/* rtl/tile_ctrl.sv */
// Write phase control for the activation buffer, instantiated once per tile in super_tile
`include "tile_cfg.svh"

module tile_ctrl
   import tile_pkg::*;
(
   input  logic      clk_h,
   input  logic      rst_n,
   input  logic      act_wr_en,     // Write strobe from the host side
   input  act_row_t  act_wr_row,    // Pair select
   input  act_pair_t act_wr_data,   // Two activations per write word
   output logic      act_we,
   output act_addr_t act_wr_addr,   // Word address into act_buf
   output act_t      act_wr_half    // Half of the pair for this phase
);

   logic phase; // Low address bit that toggles every cycle

   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         phase <= 1'b0;
      end else begin
         phase <= ~phase; // Free running and not tied to the strobe
      end
   end

   assign act_we      = act_wr_en;
   assign act_wr_addr = {act_wr_row, phase}; // Row in the upper bits

   // Phase 1 takes the upper half, phase 0 the lower half
   assign act_wr_half = phase ? act_wr_data[`TILE_ACT_WIDTH +: `TILE_ACT_WIDTH]
                              : act_wr_data[0 +: `TILE_ACT_WIDTH];

   // An unknown row or pair word would drop an X into some activation word
   a_wr_known : assert property (
      @(posedge clk_h) disable iff (!rst_n)
      act_wr_en |-> !$isunknown({act_wr_row, act_wr_data})
   ) else $error("Activation write with unknown row or data");

endmodule

/* rtl/tile_pkg.sv */
// Word and address types shared by the tile RTL and its testbench, imported by wildcard
`include "tile_cfg.svh"

package tile_pkg;

   // Weight side
   typedef logic [`TILE_W_WIDTH-1:0] weight_t;         // One weight word
   typedef logic [`TILE_W_ADDR_WIDTH-1:0] w_addr_t;    // Weight address

   // Activation side
   typedef logic [`TILE_ACT_WIDTH-1:0] act_t;          // One activation word
   typedef logic [2*`TILE_ACT_WIDTH-1:0] act_pair_t;   // Write word, two activations
   typedef logic [`TILE_ACT_ADDR_WIDTH-1:0] act_addr_t;
   // Row address, picks a pair of words
   typedef logic [`TILE_ACT_ADDR_WIDTH-2:0] act_row_t;

   // Cascade value and slice result
   typedef logic [`TILE_ACC_WIDTH-1:0] acc_t;

endpackage

/* rtl/weight_buf.sv */
// Weight memory of the tile, a block RAM with read-first port and output register
`include "tile_cfg.svh"

module weight_buf
   import tile_pkg::*;
(
   input  logic    clk_h,
   input  logic    rst_n,
   input  logic    w_wr_en,
   input  w_addr_t w_wr_addr,
   input  weight_t w_wr_data,
   input  w_addr_t w_rd_addr,
   output weight_t w_rd_data    // Two cycles after the read address
);

   weight_t mem [`TILE_W_DEPTH];   // Array, no reset
   weight_t ram_dout_q;            // Array latch, address stage

   // Power-up content, every weight reads as one until written
   initial begin
      for (int i = 0; i < `TILE_W_DEPTH; i++) begin
         mem[i] = `TILE_W_INIT;
      end
   end

   // Write port and address stage
   // Read sees the array before this edge's write, so a colliding read returns the old word
   always_ff @(posedge clk_h) begin
      if (w_wr_en) begin
         mem[w_wr_addr] <= w_wr_data;
      end
      ram_dout_q <= mem[w_rd_addr]; // Read first
   end

   // Output register, as DOA_REG on the block RAM
   always_ff @(posedge clk_h or negedge rst_n) begin
      if (!rst_n) begin
         w_rd_data <= '0;
      end else begin
         w_rd_data <= ram_dout_q;
      end
   end

   // An unknown write address would corrupt a random word that is read much later
   a_wr_known : assert property (
      @(posedge clk_h) disable iff (!rst_n)
      w_wr_en |-> !$isunknown({w_wr_addr, w_wr_data})
   ) else $error("Weight write with unknown address or data");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the tile testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_super_tile \
   -f sources.f \
   -o tb_super_tile_sim

# The testbench decides, so a nonzero simulator exit is left to the search below
out=$(./obj_dir/tb_super_tile_sim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1

/* sources.f */
+incdir+rtl
rtl/tile_pkg.sv
rtl/tile_ctrl.sv
rtl/weight_buf.sv
rtl/act_buf.sv
rtl/mac_slice.sv
rtl/super_tile.sv
tb/tb_super_tile.sv

/* tb/tb_super_tile.sv */
// Self-checking testbench for super_tile, runs directed phases then a random run against a model
`include "tile_cfg.svh"

module tb_super_tile
   import tile_pkg::*;
();

   localparam int ActDepth = 1 << `TILE_ACT_ADDR_WIDTH;

   // DUT inputs and output
   logic      clk_h;
   logic      rst_n;
   logic      w_wr_en;
   w_addr_t   w_wr_addr;
   weight_t   w_wr_data;
   w_addr_t   w_rd_addr;
   logic      act_wr_en;
   act_row_t  act_wr_row;
   act_pair_t act_wr_data;
   act_addr_t act_rd_addr;
   acc_t      p_casin;
   acc_t      p_out;

   // Model state
   weight_t wmem_m [`TILE_W_DEPTH];   // Weight copy
   act_t    amem_m [ActDepth];        // Activation copy
   logic    phase_m;                  // Phase used at the next edge
   weight_t w_hist [5];               // Weight read values, index 0 is this edge
   act_t    a_hist [4];               // Activation read values
   logic    rst_hist [4];             // rst_n seen at this and the last three edges

   logic [31:0] lfsr_q;    // Random source
   int          errors;
   int          checks;
   bit          timed_out;

   w_addr_t  wr_addrs [8];  // Addresses written in the weight phase
   act_row_t rows [3];      // Rows touched in the pair phase

   super_tile u_super_tile (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .w_wr_en     (w_wr_en),
      .w_wr_addr   (w_wr_addr),
      .w_wr_data   (w_wr_data),
      .w_rd_addr   (w_rd_addr),
      .act_wr_en   (act_wr_en),
      .act_wr_row  (act_wr_row),
      .act_wr_data (act_wr_data),
      .act_rd_addr (act_rd_addr),
      .p_casin     (p_casin),
      .p_out       (p_out)
   );

   always #50 clk_h = ~clk_h;   // 100 unit period

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         r = {r[62:0], lfsr_q[0]};
      end
      return r;
   endfunction

   task automatic set_idle();
      w_wr_en     = 1'b0;
      w_wr_addr   = '0;
      w_wr_data   = '0;
      w_rd_addr   = '0;
      act_wr_en   = 1'b0;
      act_wr_row  = '0;
      act_wr_data = '0;
      act_rd_addr = '0;
      p_casin     = '0;
   endtask

   // Called just after an edge, inputs still hold what the DUT sampled
   task automatic model_edge();
      weight_t     w_now;
      act_t        a_now;
      logic [31:0] prod;
      acc_t        exp_p;
      w_now = wmem_m[w_rd_addr];   // Reads see the memories before this edge's writes
      a_now = amem_m[act_rd_addr];
      if (w_wr_en) begin
         wmem_m[w_wr_addr] = w_wr_data;
      end
      if (act_wr_en) begin
         if (phase_m) begin
            amem_m[{act_wr_row, 1'b1}] = act_wr_data[31:16]; // Odd word, upper half
         end else begin
            amem_m[{act_wr_row, 1'b0}] = act_wr_data[15:0];  // Even word, lower half
         end
      end
      phase_m = rst_n ? ~phase_m : 1'b0;
      for (int k = 4; k > 0; k--) begin
         w_hist[k] = w_hist[k-1];
      end
      for (int k = 3; k > 0; k--) begin
         a_hist[k]   = a_hist[k-1];
         rst_hist[k] = rst_hist[k-1];
      end
      w_hist[0]   = w_now;
      a_hist[0]   = a_now;
      rst_hist[0] = rst_n;

      // Weight from edge n-4, activation from n-3, cascade from n
      prod = {16'h0, w_hist[4]} * {16'h0, a_hist[3]};
      if (!rst_hist[0]) begin
         exp_p = '0;
      end else if (rst_hist[1] && rst_hist[2] && rst_hist[3]) begin
         exp_p = {16'h0, prod} + p_casin;   // Wraps at 48 bits
      end else begin
         exp_p = p_casin;   // Operand or product stage still cleared
      end
      checks++;
      assert (p_out === exp_p) else begin
         errors++;
         $display("Error p_out expected %h got %h at %0t", exp_p, p_out, $time);
      end
   endtask

   // Edge, check at +1, return at +5 for the next drive
   task automatic tick();
      @(posedge clk_h);
      #1;
      model_edge();
      #4;
   endtask

   task automatic wait_phase(input logic want);
      int n;
      n = 0;
      while (phase_m != want && n < 4) begin
         tick();
         n++;
      end
      if (phase_m != want) begin
         $display("Timeout while waiting for write phase %0d", want);
         timed_out = 1'b1;
      end
   endtask

   // Until every pipeline stage has left reset
   task automatic wait_pipe_valid();
      int n;
      n = 0;
      while (!(rst_hist[0] && rst_hist[1] && rst_hist[2] && rst_hist[3]) && n < 8) begin
         tick();
         n++;
      end
      if (!(rst_hist[0] && rst_hist[1] && rst_hist[2] && rst_hist[3])) begin
         $display("Timeout while waiting for the pipeline to leave reset");
         timed_out = 1'b1;
      end
   endtask

   task automatic drive_random();
      w_wr_en     = (rand_bits(1) != 64'h0);
      w_wr_addr   = w_addr_t'(rand_bits(5));    // Small window, so reads hit writes
      w_wr_data   = weight_t'(rand_bits(16));
      w_rd_addr   = w_addr_t'(rand_bits(5));
      act_wr_en   = (rand_bits(1) != 64'h0);
      act_wr_row  = act_row_t'(rand_bits(5));
      act_wr_data = act_pair_t'(rand_bits(32));
      act_rd_addr = act_addr_t'(rand_bits(6));
      p_casin     = acc_t'(rand_bits(48));
   endtask

   always @(posedge timed_out) begin
      $display("Errors: %0d in %0d checks", errors, checks);
      $display("Checks failed");
      $finish;
   end

   initial begin
      clk_h   = 1'b0;
      rst_n   = 1'b0;
      lfsr_q  = 32'h9d11;
      phase_m = 1'b0;
      set_idle();
      for (int i = 0; i < `TILE_W_DEPTH; i++) begin
         wmem_m[i] = weight_t'(1);
      end
      for (int i = 0; i < ActDepth; i++) begin
         amem_m[i] = '0;
      end
      for (int k = 0; k < 5; k++) begin
         w_hist[k] = '0;
      end
      for (int k = 0; k < 4; k++) begin
         a_hist[k]   = '0;
         rst_hist[k] = 1'b0;
      end

      // Reset, all inputs zero
      repeat (3) tick();
      rst_n = 1'b1;
      wait_pipe_valid();
      repeat (4) tick();

      // Fill every pair, two cycle strobes from phase 0
      wait_phase(1'b0);
      for (int r = 0; r < 32; r++) begin
         act_wr_en   = 1'b1;
         act_wr_row  = act_row_t'(r);
         act_wr_data = act_pair_t'(rand_bits(32));
         tick();
         tick();
      end
      set_idle();
      // Untouched weights are one, so p_out is activation plus cascade
      for (int i = 0; i < 16; i++) begin
         w_rd_addr   = w_addr_t'(rand_bits(10));
         act_rd_addr = act_addr_t'(rand_bits(6));
         p_casin     = acc_t'(rand_bits(48));
         tick();
      end
      set_idle();
      repeat (5) tick();

      // Pair writes at known phase
      for (int round = 0; round < 4; round++) begin
         wait_phase(1'b0);
         act_wr_en   = 1'b1;           // Single cycle at phase 0
         act_wr_row  = act_row_t'(rand_bits(5));
         act_wr_data = act_pair_t'(rand_bits(32));
         rows[0]     = act_wr_row;
         tick();
         set_idle();
         wait_phase(1'b0);
         tick();
         act_wr_en   = 1'b1;           // Single cycle at phase 1
         act_wr_row  = act_row_t'(rand_bits(5));
         act_wr_data = act_pair_t'(rand_bits(32));
         rows[1]     = act_wr_row;
         tick();
         set_idle();
         wait_phase(1'b1);
         act_wr_en   = 1'b1;           // Two cycles from phase 1, odd then even
         act_wr_row  = act_row_t'(rand_bits(5));
         act_wr_data = act_pair_t'(rand_bits(32));
         rows[2]     = act_wr_row;
         tick();
         tick();
         set_idle();
         // Read both words of each row back
         for (int j = 0; j < 6; j++) begin
            act_rd_addr = {rows[j/2], j[0]};
            p_casin     = acc_t'(rand_bits(12));
            tick();
         end
         set_idle();
         repeat (5) tick();
      end

      // Weight writes, then readback
      for (int i = 0; i < 8; i++) begin
         w_wr_en     = 1'b1;
         w_wr_addr   = w_addr_t'(rand_bits(10));
         w_wr_data   = weight_t'(rand_bits(16));
         wr_addrs[i] = w_wr_addr;
         tick();
      end
      set_idle();
      for (int i = 0; i < 8; i++) begin
         w_rd_addr   = wr_addrs[i];
         act_rd_addr = act_addr_t'(rand_bits(6));
         p_casin     = acc_t'(rand_bits(20));
         tick();
      end
      // Read and write one address at the same edge, old word comes out
      w_wr_en     = 1'b1;
      w_wr_addr   = wr_addrs[0];
      w_wr_data   = weight_t'(rand_bits(16));
      w_rd_addr   = wr_addrs[0];
      act_rd_addr = act_addr_t'(1);
      tick();
      w_wr_en = 1'b0;
      tick();   // New word now
      set_idle();
      repeat (5) tick();

      // Cascade wraparound with full-scale operands
      w_wr_en   = 1'b1;
      w_wr_addr = 10'h3ff;
      w_wr_data = 16'hffff;
      tick();
      set_idle();
      wait_phase(1'b0);
      act_wr_en   = 1'b1;
      act_wr_row  = 5'h1f;
      act_wr_data = 32'hffff_ffff;
      tick();
      tick();
      set_idle();
      w_rd_addr   = 10'h3ff;
      act_rd_addr = 6'h3f;
      p_casin     = 48'hffff_fff0_0000;
      repeat (6) tick();
      // 0xfffe0001 on top of the cascade carries out of bit 47
      assert (p_out === 48'h0000_ffee_0001) else begin
         errors++;
         $display("Error p_out expected %h got %h", 48'h0000_ffee_0001, p_out);
      end
      set_idle();
      repeat (5) tick();

      // Random run, back to back
      for (int i = 0; i < 400; i++) begin
         drive_random();
         tick();
      end
      set_idle();
      repeat (6) tick();

      $display("Errors: %0d in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
